//--- ttc_macros.svh
// Sizes, channel count and register group offsets
// for the triple timer counter
`ifndef TTC_MACROS_SVH
`define TTC_MACROS_SVH

// Sizes --------------------------------------------
// Timer channels
`define TTC_NUM_TIMERS 3
// Counter, interval and match registers
`define TTC_CNT_W 16
// Clock and counter control registers
`define TTC_CTRL_W 7
// Interrupt status and enable registers
`define TTC_INT_W 6
`define TTC_ADDR_W 8
`define TTC_DATA_W 32

// Group bases, one word per channel at +0, +4, +8 --
`define TTC_OFS_CLK_CTRL 8'h00
`define TTC_OFS_CNTR_CTRL 8'h0C
`define TTC_OFS_COUNTER 8'h18
`define TTC_OFS_INTERVAL 8'h24
`define TTC_OFS_MATCH1 8'h30
`define TTC_OFS_MATCH2 8'h3C
`define TTC_OFS_MATCH3 8'h48
`define TTC_OFS_INTR 8'h54
`define TTC_OFS_INTR_EN 8'h60

`endif

//--- ttc_apb_pkg.sv
// Bus side: register group codes and the address decoder
`include "ttc_macros.svh"

package ttc_apb_pkg;

   localparam int unsigned GRP_W     = 4;
   localparam int unsigned GRP_BYTES = `TTC_NUM_TIMERS * 4;  // Three words per group

   // Group codes --------------------------------------
   localparam logic [GRP_W-1:0] GRP_NONE      = 4'd0;  // Unmapped, reads 0
   localparam logic [GRP_W-1:0] GRP_CLK_CTRL  = 4'd1;
   localparam logic [GRP_W-1:0] GRP_CNTR_CTRL = 4'd2;
   localparam logic [GRP_W-1:0] GRP_COUNTER   = 4'd3;  // Read only
   localparam logic [GRP_W-1:0] GRP_INTERVAL  = 4'd4;
   localparam logic [GRP_W-1:0] GRP_MATCH1    = 4'd5;
   localparam logic [GRP_W-1:0] GRP_MATCH2    = 4'd6;
   localparam logic [GRP_W-1:0] GRP_MATCH3    = 4'd7;
   localparam logic [GRP_W-1:0] GRP_INTR      = 4'd8;  // Clear on read
   localparam logic [GRP_W-1:0] GRP_INTR_EN   = 4'd9;

   // Base per code, same order as the codes
   localparam logic [`TTC_ADDR_W-1:0] GRP_BASE [1:9] = '{
      `TTC_OFS_CLK_CTRL, `TTC_OFS_CNTR_CTRL, `TTC_OFS_COUNTER,
      `TTC_OFS_INTERVAL, `TTC_OFS_MATCH1, `TTC_OFS_MATCH2,
      `TTC_OFS_MATCH3, `TTC_OFS_INTR, `TTC_OFS_INTR_EN};

   // Address to group code and channel 1..3
   function automatic void ttc_decode_addr(
      input  logic [`TTC_ADDR_W-1:0] addr,
      output logic [GRP_W-1:0]       grp,
      output logic [1:0]             chan
   );
      logic [`TTC_ADDR_W-1:0] rel;
      grp  = GRP_NONE;
      chan = 2'd0;
      for (int g = 1; g <= 9; g++) begin
         rel = addr - GRP_BASE[g];  // Wraps high when below the base
         if (rel < GRP_BYTES && rel[1:0] == 2'b00) begin
            grp  = g[GRP_W-1:0];
            chan = rel[3:2] + 2'd1;
         end
      end
   endfunction

endpackage

//--- ttc_timer_pkg.sv
// Timer side: control word union and interrupt bit positions
`include "ttc_macros.svh"

package ttc_timer_pkg;

   // One stored control word, decoded as clock or counter control
   typedef union packed {
      struct packed {
         logic       edge_neg;       // Stored only
         logic       src_ext;        // Stored only
         logic [3:0] ps_sel;         // Prescale N
         logic       ps_en;
      } clk;
      struct packed {
         logic wave_pol;             // Stored only
         logic wave_dis;             // Stored only
         logic cnt_reset;            // Self clearing
         logic match_en;
         logic decrement;
         logic interval_mode;
         logic cnt_dis;
      } cntr;
   } ttc_ctrl_word_u;

   localparam ttc_ctrl_word_u CNTR_CTRL_RST = 7'b000_0001;  // Counter held off

   // Interrupt status bits
   localparam int INTR_INTERVAL = 0;
   localparam int INTR_MATCH1   = 1;
   localparam int INTR_MATCH2   = 2;
   localparam int INTR_MATCH3   = 3;
   localparam int INTR_OVERFLOW = 4;
   localparam int INTR_EVENT    = 5;  // No event timer, always 0

endpackage

//--- ttc_interface_lite.sv
// Bus register interface: address decode, write strobes,
// read mux and read-clear of the interrupt registers
`include "ttc_macros.svh"

module ttc_interface_lite
   import ttc_apb_pkg::*;
(
   input  logic                                        pclk,
   input  logic                                        arst_n,
   input  logic                                        psel,
   input  logic                                        penable,
   input  logic                                        pwrite,
   input  logic [`TTC_ADDR_W-1:0]                      paddr,
   input  logic [`TTC_NUM_TIMERS:1][`TTC_CTRL_W-1:0]   clk_ctrl,
   input  logic [`TTC_NUM_TIMERS:1][`TTC_CTRL_W-1:0]   cntr_ctrl,
   input  logic [`TTC_NUM_TIMERS:1][`TTC_CNT_W-1:0]    counter_val,
   input  logic [`TTC_NUM_TIMERS:1][`TTC_CNT_W-1:0]    interval,
   input  logic [`TTC_NUM_TIMERS:1][`TTC_CNT_W-1:0]    match1,
   input  logic [`TTC_NUM_TIMERS:1][`TTC_CNT_W-1:0]    match2,
   input  logic [`TTC_NUM_TIMERS:1][`TTC_CNT_W-1:0]    match3,
   input  logic [`TTC_NUM_TIMERS:1][`TTC_INT_W-1:0]    intr_status,
   input  logic [`TTC_NUM_TIMERS:1][`TTC_INT_W-1:0]    intr_en,
   output logic [`TTC_DATA_W-1:0]                      prdata,
   output logic [`TTC_NUM_TIMERS:1]                    clk_ctrl_sel,
   output logic [`TTC_NUM_TIMERS:1]                    cntr_ctrl_sel,
   output logic [`TTC_NUM_TIMERS:1]                    interval_sel,
   output logic [`TTC_NUM_TIMERS:1]                    match1_sel,
   output logic [`TTC_NUM_TIMERS:1]                    match2_sel,
   output logic [`TTC_NUM_TIMERS:1]                    match3_sel,
   output logic [`TTC_NUM_TIMERS:1]                    intr_en_sel,
   output logic [`TTC_NUM_TIMERS:1]                    clear_interrupt
);

   logic [GRP_W-1:0]         grp;         // Decoded register group
   logic [1:0]               chan;        // Channel 1..3
   logic [`TTC_NUM_TIMERS:1] chan_hot;    // One-hot channel
   logic                     setup_done;  // Last cycle was a setup phase
   logic                     wr_acc;
   logic                     rd_acc;

   // Decode ------------------------------------------
   always_comb begin
      ttc_decode_addr(paddr, grp, chan);
      chan_hot = '0;
      if (grp != GRP_NONE) begin
         chan_hot[chan] = 1'b1;
      end
   end

   // Access phase only counts after its setup phase
   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         setup_done <= 1'b0;
      end else begin
         setup_done <= psel & ~penable;
      end
   end

   assign wr_acc = psel & penable & setup_done & pwrite;
   assign rd_acc = psel & penable & setup_done & ~pwrite;

   // Write strobes, one cycle wide
   assign clk_ctrl_sel  = (wr_acc && grp == GRP_CLK_CTRL)  ? chan_hot : '0;
   assign cntr_ctrl_sel = (wr_acc && grp == GRP_CNTR_CTRL) ? chan_hot : '0;
   assign interval_sel  = (wr_acc && grp == GRP_INTERVAL)  ? chan_hot : '0;
   assign match1_sel    = (wr_acc && grp == GRP_MATCH1)    ? chan_hot : '0;
   assign match2_sel    = (wr_acc && grp == GRP_MATCH2)    ? chan_hot : '0;
   assign match3_sel    = (wr_acc && grp == GRP_MATCH3)    ? chan_hot : '0;
   assign intr_en_sel   = (wr_acc && grp == GRP_INTR_EN)   ? chan_hot : '0;

   // Status clears at the edge ending the read
   assign clear_interrupt = (rd_acc && grp == GRP_INTR) ? chan_hot : '0;

   // Read mux -----------------------------------------
   always_comb begin
      prdata = '0;  // Idle and unmapped read 0
      if (rd_acc) begin
         case (grp)
            GRP_CLK_CTRL:  prdata[`TTC_CTRL_W-1:0] = clk_ctrl[chan];
            GRP_CNTR_CTRL: prdata[`TTC_CTRL_W-1:0] = cntr_ctrl[chan];
            GRP_COUNTER:   prdata[`TTC_CNT_W-1:0]  = counter_val[chan];
            GRP_INTERVAL:  prdata[`TTC_CNT_W-1:0]  = interval[chan];
            GRP_MATCH1:    prdata[`TTC_CNT_W-1:0]  = match1[chan];
            GRP_MATCH2:    prdata[`TTC_CNT_W-1:0]  = match2[chan];
            GRP_MATCH3:    prdata[`TTC_CNT_W-1:0]  = match3[chan];
            GRP_INTR:      prdata[`TTC_INT_W-1:0]  = intr_status[chan];  // Old value
            GRP_INTR_EN:   prdata[`TTC_INT_W-1:0]  = intr_en[chan];
            default:       prdata = '0;
         endcase
      end
   end

endmodule

//--- ttc_prescaler.sv
// Prescaler: count-enable tick for one timer channel
`include "ttc_macros.svh"

module ttc_prescaler
   import ttc_timer_pkg::*;
(
   input  logic                   pclk,
   input  logic                   arst_n,
   input  logic [`TTC_CTRL_W-1:0] clk_ctrl,
   input  logic                   counter_reset,
   output logic                   tick
);

   ttc_ctrl_word_u ctrl;   // Clock view of the stored word
   logic [16:0]    div_q;  // Free-running divider
   logic [16:0]    mask;   // Low N+1 bits set

   assign ctrl = clk_ctrl;
   assign mask = (17'd2 << ctrl.clk.ps_sel) - 17'd1;

   // One tick per 2**(N+1) cycles, or every cycle when off
   assign tick = ctrl.clk.ps_en ? &(div_q | ~mask) : 1'b1;

   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         div_q <= '0;
      end else if (counter_reset) begin
         div_q <= '0;  // Next tick a full period away
      end else begin
         div_q <= div_q + 17'd1;
      end
   end

endmodule

//--- ttc_timer_counter_lite.sv
// One timer channel: registers, up/down counter,
// match compare and interrupt status
`include "ttc_macros.svh"

module ttc_timer_counter_lite
   import ttc_timer_pkg::*;
(
   input  logic                   pclk,
   input  logic                   arst_n,
   input  logic [`TTC_CNT_W-1:0]  pwdata,
   input  logic                   clk_ctrl_sel,
   input  logic                   cntr_ctrl_sel,
   input  logic                   interval_sel,
   input  logic                   match1_sel,
   input  logic                   match2_sel,
   input  logic                   match3_sel,
   input  logic                   intr_en_sel,
   input  logic                   clear_interrupt,
   output logic [`TTC_CTRL_W-1:0] clk_ctrl,
   output logic [`TTC_CTRL_W-1:0] cntr_ctrl,
   output logic [`TTC_CNT_W-1:0]  counter_val,
   output logic [`TTC_CNT_W-1:0]  interval,
   output logic [`TTC_CNT_W-1:0]  match1,
   output logic [`TTC_CNT_W-1:0]  match2,
   output logic [`TTC_CNT_W-1:0]  match3,
   output logic [`TTC_INT_W-1:0]  intr_status,
   output logic [`TTC_INT_W-1:0]  intr_en,
   output logic                   interrupt
);

   ttc_ctrl_word_u        wr_word;   // Write data, both views
   ttc_ctrl_word_u        cntr_q;    // Counter control
   logic                  tick;
   logic                  step;      // Counter moves this cycle
   logic                  cnt_rst;   // Counter reset write
   logic [`TTC_CNT_W-1:0] cnt_next;
   logic [`TTC_INT_W-1:0] ev;        // Events of this step

   assign wr_word   = pwdata[`TTC_CTRL_W-1:0];
   assign cnt_rst   = cntr_ctrl_sel & wr_word.cntr.cnt_reset;
   assign cntr_ctrl = cntr_q;
   assign step      = tick & ~cntr_q.cntr.cnt_dis & ~cnt_rst;

   ttc_prescaler i_prescaler (
      .pclk          (pclk),
      .arst_n        (arst_n),
      .clk_ctrl      (clk_ctrl),
      .counter_reset (cnt_rst),
      .tick          (tick)
   );

   // Register writes ----------------------------------
   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         clk_ctrl <= '0;
         cntr_q   <= CNTR_CTRL_RST;
         interval <= '0;
         match1   <= '0;
         match2   <= '0;
         match3   <= '0;
         intr_en  <= '0;
      end else begin
         if (clk_ctrl_sel) clk_ctrl <= wr_word;
         if (cntr_ctrl_sel) begin
            cntr_q                <= wr_word;
            cntr_q.cntr.cnt_reset <= 1'b0;  // Reads back 0
         end
         if (interval_sel) interval <= pwdata;
         if (match1_sel)   match1   <= pwdata;
         if (match2_sel)   match2   <= pwdata;
         if (match3_sel)   match3   <= pwdata;
         if (intr_en_sel)  intr_en  <= pwdata[`TTC_INT_W-1:0];
      end
   end

   // Next count and events
   always_comb begin
      cnt_next = counter_val;
      ev       = '0;
      if (step) begin
         if (cntr_q.cntr.decrement) begin
            if (cntr_q.cntr.interval_mode && counter_val == '0) begin
               cnt_next           = interval;  // Reload
               ev[INTR_INTERVAL] = 1'b1;
            end else begin
               cnt_next           = counter_val - 1'b1;
               ev[INTR_OVERFLOW] = !cntr_q.cntr.interval_mode && counter_val == '0;
            end
         end else begin
            if (cntr_q.cntr.interval_mode && counter_val == interval) begin
               cnt_next           = '0;  // Wrap at interval
               ev[INTR_INTERVAL] = 1'b1;
            end else begin
               cnt_next           = counter_val + 1'b1;
               ev[INTR_OVERFLOW] = !cntr_q.cntr.interval_mode && &counter_val;
            end
         end
         if (cntr_q.cntr.match_en) begin  // Step onto a match value
            ev[INTR_MATCH1] = cnt_next == match1;
            ev[INTR_MATCH2] = cnt_next == match2;
            ev[INTR_MATCH3] = cnt_next == match3;
         end
      end
      ev[INTR_EVENT] = 1'b0;
   end

   // Counter and status -------------------------------
   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         counter_val <= '0;
         intr_status <= '0;
      end else begin
         if (cnt_rst) begin
            counter_val <= wr_word.cntr.decrement ? interval : '0;
         end else begin
            counter_val <= cnt_next;
         end
         // New event wins over read-clear
         intr_status <= (clear_interrupt ? '0 : intr_status) | ev;
      end
   end

   assign interrupt = |(intr_status & intr_en);  // Level, enabled bits only

endmodule

//--- ttc_lite.sv
// Triple timer counter top: bus interface and three channels
`include "ttc_macros.svh"

module ttc_lite (
   input  logic                       pclk,
   input  logic                       arst_n,
   input  logic                       psel,
   input  logic                       penable,
   input  logic                       pwrite,
   input  logic [`TTC_ADDR_W-1:0]     paddr,
   input  logic [`TTC_DATA_W-1:0]     pwdata,
   output logic [`TTC_DATA_W-1:0]     prdata,
   output logic [`TTC_NUM_TIMERS:1]   interrupt
);

   // Channel registers back to the read mux
   logic [`TTC_NUM_TIMERS:1][`TTC_CTRL_W-1:0] clk_ctrl;
   logic [`TTC_NUM_TIMERS:1][`TTC_CTRL_W-1:0] cntr_ctrl;
   logic [`TTC_NUM_TIMERS:1][`TTC_CNT_W-1:0]  counter_val;
   logic [`TTC_NUM_TIMERS:1][`TTC_CNT_W-1:0]  interval;
   logic [`TTC_NUM_TIMERS:1][`TTC_CNT_W-1:0]  match1;
   logic [`TTC_NUM_TIMERS:1][`TTC_CNT_W-1:0]  match2;
   logic [`TTC_NUM_TIMERS:1][`TTC_CNT_W-1:0]  match3;
   logic [`TTC_NUM_TIMERS:1][`TTC_INT_W-1:0]  intr_status;
   logic [`TTC_NUM_TIMERS:1][`TTC_INT_W-1:0]  intr_en;
   // Strobes, one bit per channel
   logic [`TTC_NUM_TIMERS:1]                  clk_ctrl_sel;
   logic [`TTC_NUM_TIMERS:1]                  cntr_ctrl_sel;
   logic [`TTC_NUM_TIMERS:1]                  interval_sel;
   logic [`TTC_NUM_TIMERS:1]                  match1_sel;
   logic [`TTC_NUM_TIMERS:1]                  match2_sel;
   logic [`TTC_NUM_TIMERS:1]                  match3_sel;
   logic [`TTC_NUM_TIMERS:1]                  intr_en_sel;
   logic [`TTC_NUM_TIMERS:1]                  clear_interrupt;

   ttc_interface_lite i_ttc_interface_lite (.*);

   // Channels ------------------------------------------
   ttc_timer_counter_lite i_timer_1 (
      .pclk, .arst_n, .pwdata(pwdata[`TTC_CNT_W-1:0]),
      .clk_ctrl_sel(clk_ctrl_sel[1]), .cntr_ctrl_sel(cntr_ctrl_sel[1]),
      .interval_sel(interval_sel[1]), .match1_sel(match1_sel[1]),
      .match2_sel(match2_sel[1]), .match3_sel(match3_sel[1]),
      .intr_en_sel(intr_en_sel[1]), .clear_interrupt(clear_interrupt[1]),
      .clk_ctrl(clk_ctrl[1]), .cntr_ctrl(cntr_ctrl[1]), .counter_val(counter_val[1]),
      .interval(interval[1]), .match1(match1[1]), .match2(match2[1]), .match3(match3[1]),
      .intr_status(intr_status[1]), .intr_en(intr_en[1]), .interrupt(interrupt[1])
   );

   ttc_timer_counter_lite i_timer_2 (
      .pclk, .arst_n, .pwdata(pwdata[`TTC_CNT_W-1:0]),
      .clk_ctrl_sel(clk_ctrl_sel[2]), .cntr_ctrl_sel(cntr_ctrl_sel[2]),
      .interval_sel(interval_sel[2]), .match1_sel(match1_sel[2]),
      .match2_sel(match2_sel[2]), .match3_sel(match3_sel[2]),
      .intr_en_sel(intr_en_sel[2]), .clear_interrupt(clear_interrupt[2]),
      .clk_ctrl(clk_ctrl[2]), .cntr_ctrl(cntr_ctrl[2]), .counter_val(counter_val[2]),
      .interval(interval[2]), .match1(match1[2]), .match2(match2[2]), .match3(match3[2]),
      .intr_status(intr_status[2]), .intr_en(intr_en[2]), .interrupt(interrupt[2])
   );

   ttc_timer_counter_lite i_timer_3 (
      .pclk, .arst_n, .pwdata(pwdata[`TTC_CNT_W-1:0]),
      .clk_ctrl_sel(clk_ctrl_sel[3]), .cntr_ctrl_sel(cntr_ctrl_sel[3]),
      .interval_sel(interval_sel[3]), .match1_sel(match1_sel[3]),
      .match2_sel(match2_sel[3]), .match3_sel(match3_sel[3]),
      .intr_en_sel(intr_en_sel[3]), .clear_interrupt(clear_interrupt[3]),
      .clk_ctrl(clk_ctrl[3]), .cntr_ctrl(cntr_ctrl[3]), .counter_val(counter_val[3]),
      .interval(interval[3]), .match1(match1[3]), .match2(match2[3]), .match3(match3[3]),
      .intr_status(intr_status[3]), .intr_en(intr_en[3]), .interrupt(interrupt[3])
   );

endmodule

//--- tb_ttc_checker.sv
// Checker: read data and interrupt pattern compare,
// per-test result lines and the closing counts
module tb_ttc_checker (
   input  logic            pclk,
   input  logic            psel,
   input  logic            penable,
   input  logic            pwrite,
   input  logic [7:0]      paddr,
   input  logic [31:0]     prdata,
   input  logic [31:0]     rd_exp,
   input  logic [3:1]      interrupt,
   input  logic [3:1]      wait_exp,
   input  logic            wait_done,
   input  logic            wait_to,
   input  logic            test_end,
   input  logic            sim_end,
   input  logic [8*24-1:0] test_name,
   output int              err_count
);
   timeunit 1ns;
   timeprecision 100ps;

   int errs      = 0;
   int test_errs = 0;  // Errors of the running test
   int checks    = 0;
   int tests     = 0;

   assign err_count = errs;

   // Mid-cycle sampling, bus inputs move 1 ns after the rising edge
   always @(negedge pclk) begin
      if (psel && penable && !pwrite) begin  // Read access cycle
         checks++;
         if (prdata !== rd_exp) begin
            $display("Mismatch prdata at 0x%02h: expected 0x%08h, actual 0x%08h",
                     paddr, rd_exp, prdata);
            errs++;
            test_errs++;
         end
      end
      if (wait_done) begin
         checks++;
         if (wait_to) begin
            $display("Timed out waiting for interrupt pattern 0x%h, still at 0x%h",
                     wait_exp, interrupt);
            errs++;
            test_errs++;
         end else if (interrupt !== wait_exp) begin
            $display("Mismatch interrupt: expected 0x%h, actual 0x%h",
                     wait_exp, interrupt);
            errs++;
            test_errs++;
         end
      end
      if (test_end) begin
         tests++;
         $display("Test %0s finished, %0d errors", test_name, test_errs);
         test_errs = 0;
      end
      if (sim_end) begin
         $display("Tests %0d, checks %0d, errors %0d", tests, checks, errs);
      end
   end

endmodule

//--- tb_ttc_lite.sv
// Testbench top: clock, reset, golden-file driven bus master,
// LFSR random source, DUT and checker instances
module tb_ttc_lite;
   timeunit 1ns;
   timeprecision 100ps;

   logic            pclk;
   logic            arst_n;
   logic            psel;
   logic            penable;
   logic            pwrite;
   logic [7:0]      paddr;
   logic [31:0]     pwdata;
   logic [31:0]     prdata;
   logic [3:1]      interrupt;
   // Driver to checker
   logic [31:0]     rd_exp;      // Expected data of the current read
   logic            wait_done;   // Interrupt wait just ended
   logic            wait_to;     // ... without reaching its pattern
   logic [3:1]      wait_exp;
   logic            test_end;
   logic            sim_end;
   logic [8*24-1:0] test_name;
   int              err_count;
   logic [15:0]     lfsr;
   logic            setup_err;   // Golden file missing or malformed

   ttc_lite ttc_lite_inst (.*);
   tb_ttc_checker i_checker (.*);

   initial pclk = 1'b0;
   always #5 pclk = ~pclk;  // 10 ns period

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit taken
   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   // Bus transfers ------------------------------------
   task automatic bus_xfer(input logic wr, input logic [7:0] a, input logic [31:0] d);
      @(posedge pclk);
      #1;
      psel   = 1'b1;  // Setup
      pwrite = wr;
      paddr  = a;
      pwdata = wr ? d : 32'h0;
      rd_exp = wr ? 32'h0 : d;
      @(posedge pclk);
      #1;
      penable = 1'b1;  // Access
      @(posedge pclk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // Poll interrupt up to limit cycles, then hand result to checker
   task automatic wait_intr(input logic [3:1] pat, input int limit);
      int   n;
      logic timed_out;
      n = 0;
      while (interrupt !== pat && n < limit) begin
         @(negedge pclk);
         n++;
      end
      timed_out = (interrupt !== pat);  // Where the poll stopped
      @(posedge pclk);
      #1;
      wait_exp  = pat;
      wait_to   = timed_out;
      wait_done = 1'b1;
      @(posedge pclk);
      #1;
      wait_done = 1'b0;
   endtask

   task automatic pulse_test_end();
      @(posedge pclk);
      #1;
      test_end = 1'b1;
      @(posedge pclk);
      #1;
      test_end = 1'b0;
   endtask

   // Interval and match registers only, expected is the low half word
   task automatic random_readback(input int count);
      logic [31:0] ch;
      logic [31:0] sel;
      logic [31:0] d;
      logic [7:0]  base;
      for (int i = 0; i < count; i++) begin
         rand_bits(2, ch);
         rand_bits(2, sel);
         rand_bits(32, d);
         ch = ch % 3;
         case (sel[1:0])
            2'd0: base = 8'h24;
            2'd1: base = 8'h30;
            2'd2: base = 8'h3C;
            default: base = 8'h48;
         endcase
         bus_xfer(1'b1, base + 8'(ch * 4), d);
         bus_xfer(1'b0, base + 8'(ch * 4), {16'h0, d[15:0]});
      end
   endtask

   // Golden file interpreter ---------------------------
   initial begin
      int          fd;
      int          cnt;
      logic [31:0] a;
      logic [31:0] b;
      string       line;
      logic        in_test;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      rd_exp    = '0;
      wait_done = 1'b0;
      wait_to   = 1'b0;
      wait_exp  = '0;
      test_end  = 1'b0;
      sim_end   = 1'b0;
      test_name = '0;
      setup_err = 1'b0;
      in_test   = 1'b0;
      lfsr      = 16'd8130;
      arst_n    = 1'b0;
      repeat (8) @(posedge pclk);
      #1;
      arst_n = 1'b1;
      fd = $fopen("ttc_golden.txt", "r");
      if (fd == 0) begin
         $display("Could not open ttc_golden.txt");
         setup_err = 1'b1;
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") continue;  // Blank or comment
            case (line[0])
               "W": begin
                  void'($sscanf(line, "W %h %h", a, b));
                  bus_xfer(1'b1, a[7:0], b);
               end
               "R": begin
                  void'($sscanf(line, "R %h %h", a, b));
                  bus_xfer(1'b0, a[7:0], b);
               end
               "I": begin
                  void'($sscanf(line, "I %h %d", a, cnt));
                  wait_intr(a[2:0], cnt);
               end
               "D": begin
                  void'($sscanf(line, "D %d", cnt));
                  repeat (cnt) @(posedge pclk);
                  #1;
               end
               "X": begin
                  void'($sscanf(line, "X %d", cnt));
                  random_readback(cnt);
               end
               "T": begin
                  if (in_test) pulse_test_end();
                  void'($sscanf(line, "T %s", test_name));
                  in_test = 1'b1;
               end
               default: begin
                  $display("Unknown command in golden file: %0s", line);
                  setup_err = 1'b1;
               end
            endcase
         end
         if (in_test) pulse_test_end();
         $fclose(fd);
      end
      @(posedge pclk);
      #1;
      sim_end = 1'b1;  // Checker prints the counts
      @(posedge pclk);
      #1;
      sim_end = 1'b0;
      @(posedge pclk);
      if (err_count == 0 && !setup_err) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

//--- ttc_golden.txt
# W addr data | R addr expected | I pattern(hex) limit(cycles) | D cycles
# T name | X count (random interval/match readback); numbers hex unless noted
T reset
I 0 4
R 00 0
R 0C 1
R 14 1
R 18 0
R 2C 0
R 30 0
R 44 0
R 50 0
R 54 0
R 68 0
T readback
W 04 0000FFFF
R 04 7F
W 10 FFFFFFFF
R 10 6F
W 28 ABCD1234
R 28 1234
W 34 FFFF5A5A
R 34 5A5A
W 40 1
R 40 1
W 50 8000
R 50 8000
W 64 FF
R 64 3F
W 64 0
W 04 0
W 10 1
T random
X 12
T interval
W 24 14
W 60 1
W 0C 12
I 1 40
R 54 1
R 54 0
I 0 4
W 0C 1
R 54 0
W 00 3
W 0C 12
I 1 150
R 54 1
W 0C 1
R 54 0
I 0 4
W 00 0
T match_overflow
W 64 1E
W 34 5
W 40 9
W 4C D
W 10 18
I 2 40
D 20
W 10 1
R 58 0E
W 28 FFFC
W 10 15
W 10 0
I 2 20
W 10 1
R 58 10
T masking
W 04 1
W 28 5
W 10 16
W 2C 3
W 14 12
D 20
I 0 4
W 68 1
I 4 10
W 14 1
W 10 1
R 5C 1
R 58 1
R 5C 0
I 0 4

//--- ttc_lite.f
+incdir+.
ttc_apb_pkg.sv
ttc_timer_pkg.sv
ttc_interface_lite.sv
ttc_prescaler.sv
ttc_timer_counter_lite.sv
ttc_lite.sv
tb_ttc_checker.sv
tb_ttc_lite.sv

//--- Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_ttc_lite
FILELIST   = ttc_lite.f
BIN        = obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
